// ==== mem_dp.sv ====
/*
 * Multi-port flop memory
 * Gated combinational reads, optional write-to-read bypass,
 * writes applied in port order so the highest port wins
 */

module mem_dp #(
    parameter int WIDTH       = 32,
    parameter int DEPTH       = 64,
    parameter int READ_PORTS  = 2,
    parameter int WRITE_PORTS = 1,
    parameter bit BYPASS_EN   = 1'b1
) (
    input  logic                                      clock,
    input  logic                                      reset,
    // Read ports
    input  logic [READ_PORTS-1:0]                     re,
    input  logic [READ_PORTS-1:0][$clog2(DEPTH)-1:0]  raddr,
    output logic [READ_PORTS-1:0][WIDTH-1:0]          rdata,
    // Write ports
    input  logic [WRITE_PORTS-1:0]                    we,
    input  logic [WRITE_PORTS-1:0][$clog2(DEPTH)-1:0] waddr,
    input  logic [WRITE_PORTS-1:0][WIDTH-1:0]         wdata
);

    // Storage, contents are not cleared
    logic [WIDTH-1:0] mem [DEPTH];

    ////////////////////////////////////////
    // Write side
    ////////////////////////////////////////

    // Later ports overwrite earlier ones in the same cycle
    always_ff @(posedge clock) begin
        if (!reset) begin
            for (int w = 0; w < WRITE_PORTS; w++) begin
                if (we[w]) begin
                    mem[waddr[w]] <= wdata[w];
                end
            end
        end
    end

    ////////////////////////////////////////
    // Read side
    ////////////////////////////////////////

    always_comb begin
        for (int r = 0; r < READ_PORTS; r++) begin
            // Disabled port reads zero
            rdata[r] = '0;
            if (re[r]) begin
                rdata[r] = mem[raddr[r]];
                // Forward same-cycle write data
                // scanning upward so the highest matching port is kept
                if (BYPASS_EN) begin
                    for (int w = 0; w < WRITE_PORTS; w++) begin
                        if (we[w] && (waddr[w] == raddr[r])) begin
                            rdata[r] = wdata[w];
                        end
                    end
                end
            end
        end
    end

endmodule

// ==== prf_debug_ctrl.sv ====
/*
 * Register file debug controller
 * Clears every register after reset, then serves APB accesses
 * through the debug read and write ports with one wait state
 */

module prf_debug_ctrl
    import sys_defs_pkg::*;
(
    input  logic                  clock,
    input  logic                  reset,
    // APB slave
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [APB_ADDR_W-1:0] paddr,
    input  DATA                   pwdata,
    output DATA                   prdata,
    output logic                  pready,
    output logic                  pslverr,
    // Clearing status
    output logic                  init_busy,
    // Index counter
    output logic                  count_en,
    input  REG_IDX                index,
    input  logic                  last,
    // Debug ports of the register file
    output REG_IDX                dbg_read_idx,
    input  DATA                   dbg_read_data,
    output logic                  dbg_write_en,
    output REG_IDX                dbg_write_idx,
    output DATA                   dbg_write_data
);

    typedef enum logic [1:0] {
        INIT,
        IDLE,
        RESP
    } state_t;

    state_t state;
    state_t next_state;
    logic   access;
    logic   addr_ok;

    ////////////////////////////////////////
    // Address decode
    ////////////////////////////////////////

    // Access phase, paddr held stable by the master
    assign access       = psel & penable;
    assign addr_ok      = (paddr[APB_ADDR_W-1:APB_HI_LSB] == '0);
    assign dbg_read_idx = paddr[APB_IDX_MSB:APB_IDX_LSB];

    ////////////////////////////////////////
    // FSM
    ////////////////////////////////////////

    always_comb begin
        next_state = state;
        case (state)
            INIT: if (last) next_state = IDLE;
            IDLE: if (access) next_state = RESP;
            RESP: next_state = IDLE;
            default: next_state = INIT;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= INIT;
        end else begin
            state <= next_state;
        end
    end

    assign init_busy = (state == INIT);
    // Counter steps once per cleared register
    assign count_en  = (state == INIT);

    // Response flags, high for the single RESP cycle
    always_ff @(posedge clock) begin
        if (reset) begin
            pready  <= 1'b0;
            pslverr <= 1'b0;
        end else begin
            pready  <= (state == IDLE) && access;
            pslverr <= (state == IDLE) && access && !addr_ok;
        end
    end

    // Read data captured as the access is accepted
    always_ff @(posedge clock) begin
        if ((state == IDLE) && access) begin
            prdata <= addr_ok ? dbg_read_data : '0;
        end
    end

    // Debug write port
    always_comb begin
        dbg_write_en   = 1'b0;
        dbg_write_idx  = index;
        dbg_write_data = '0;
        case (state)
            // Zero fill at the counter's index
            INIT: dbg_write_en = 1'b1;
            // Lands on the edge that ends the pready cycle
            RESP: begin
                dbg_write_en   = pwrite & addr_ok;
                dbg_write_idx  = dbg_read_idx;
                dbg_write_data = pwdata;
            end
            default: dbg_write_en = 1'b0;
        endcase
    end

endmodule

// ==== prf_index_counter.sv ====
/*
 * Physical index counter
 * Walks 1 to PHYS_REG_SZ-1 and flags the last index
 */

module prf_index_counter
    import sys_defs_pkg::*;
(
    input  logic   clock,
    input  logic   reset,
    input  logic   count_en,
    output REG_IDX index,
    output logic   last
);

    assign last = (index == LAST_REG);

    // Zero register is skipped, wrap goes back to 1
    always_ff @(posedge clock) begin
        if (reset) begin
            index <= REG_IDX'(1);
        end else if (count_en) begin
            if (last) begin
                index <= REG_IDX'(1);
            end else begin
                index <= index + REG_IDX'(1);
            end
        end
    end

endmodule

// ==== prf_properties.sv ====
/*
 * Bound assertions on the APB response and the clearing status
 */

module prf_properties (
    input logic clock,
    input logic reset,
    input logic pready,
    input logic pslverr,
    input logic init_busy
);

    timeunit 1ns;
    timeprecision 100ps;

    // No response while registers are still being cleared
    no_ready_in_clear: assert property (@(posedge clock) disable iff (reset)
        init_busy |-> !pready)
        else $error("pready high while init_busy is high");

    // Error flag only rides on a response
    err_with_ready: assert property (@(posedge clock) disable iff (reset)
        pslverr |-> pready)
        else $error("pslverr high without pready");

    // One response cycle per access
    ready_one_cycle: assert property (@(posedge clock) disable iff (reset)
        pready |=> !pready)
        else $error("pready high for more than one cycle");

    // Clearing happens once per reset
    busy_stays_low: assert property (@(posedge clock) disable iff (reset)
        !init_busy |=> !init_busy)
        else $error("init_busy rose again without reset");

endmodule

bind prf_top prf_properties props0 (
    .clock    (clock),
    .reset    (reset),
    .pready   (pready),
    .pslverr  (pslverr),
    .init_busy(init_busy)
);

// ==== prf_tb.sv ====
/*
 * Directed testbench for the physical register file subsystem
 * Covers clearing, lane ports, the zero register, APB access and write priority
 */

module prf_tb
    import sys_defs_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    // Upper bound on any wait, in cycles
    localparam int WAIT_LIMIT = 200;

    logic                  clock = 1'b0;
    logic                  reset;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [APB_ADDR_W-1:0] paddr;
    DATA                   pwdata;
    DATA                   prdata;
    logic                  pready;
    logic                  pslverr;
    logic                  init_busy;
    REG_IDX [NUM_FU-1:0]   read_idx_1;
    REG_IDX [NUM_FU-1:0]   read_idx_2;
    DATA    [NUM_FU-1:0]   read_out_1;
    DATA    [NUM_FU-1:0]   read_out_2;
    logic   [NUM_FU-1:0]   write_en;
    REG_IDX [NUM_FU-1:0]   write_idx;
    DATA    [NUM_FU-1:0]   write_data;

    // Expected register contents
    DATA    ref_regs [PHYS_REG_SZ];
    integer seed;
    int     errors = 0;
    int     checks = 0;
    int     tests = 0;

    prf_top dut0 (.*);

    // 100 ns period
    always #50 clock = ~clock;

    ////////////////////////////////////////
    // Compare and helper routines
    ////////////////////////////////////////

    task automatic check_data(input DATA got, input DATA exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0d ns: %s read %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0d ns: %s was %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic timeout_abort(input string what);
        $display("Timeout: no %s within %0d cycles, run stopped", what, WAIT_LIMIT);
        $display("sim failed");
        $finish;
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests++;
        $display("test %-12s done, %0d errors", name, errors - errors_before);
    endtask

    // Word aligned window, index in bits 7 to 2
    function automatic logic [APB_ADDR_W-1:0] apb_addr(input REG_IDX idx);
        return {{(APB_ADDR_W - APB_HI_LSB){1'b0}}, idx, {APB_IDX_LSB{1'b0}}};
    endfunction

    // Random nonzero index
    function automatic REG_IDX rand_idx();
        return REG_IDX'(1 + ({$random(seed)} % (PHYS_REG_SZ - 1)));
    endfunction

    function automatic DATA rand_data();
        return DATA'($random(seed));
    endfunction

    ////////////////////////////////////////
    // Drivers, all start and end 1 ns after a rising edge
    ////////////////////////////////////////

    task automatic reset_dut();
        reset = 1'b1;
        repeat (16) @(posedge clock);
        #1;
        reset = 1'b0;
        // Clearing zeroes every register
        for (int i = 0; i < PHYS_REG_SZ; i++) begin
            ref_regs[i] = '0;
        end
    endtask

    task automatic apb_xfer(input logic wr, input logic [APB_ADDR_W-1:0] addr,
                            input DATA wdata, output DATA rdata, output logic err,
                            output int waits, output int busy_waits);
        waits = 0;
        busy_waits = 0;
        // Setup phase
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clock);
        #1;
        penable = 1'b1;
        // Access phase, counted in cycles until pready
        do begin
            @(negedge clock);
            waits++;
            if (init_busy) busy_waits++;
            if (waits > WAIT_LIMIT) timeout_abort("pready on APB access");
        end while (!pready);
        rdata = prdata;
        err   = pslverr;
        @(posedge clock);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [APB_ADDR_W-1:0] addr, input DATA wdata,
                             input logic exp_err);
        DATA  rdata;
        logic err;
        int   waits;
        int   busy_waits;
        apb_xfer(1'b1, addr, wdata, rdata, err, waits, busy_waits);
        check_flag(err, exp_err, "APB write pslverr");
        check_flag(waits == 2, 1'b1, "APB write pready in second access cycle");
    endtask

    task automatic apb_read(input logic [APB_ADDR_W-1:0] addr, input DATA exp,
                            input logic exp_err);
        DATA  rdata;
        logic err;
        int   waits;
        int   busy_waits;
        apb_xfer(1'b0, addr, '0, rdata, err, waits, busy_waits);
        check_flag(err, exp_err, "APB read pslverr");
        check_flag(waits == 2, 1'b1, "APB read pready in second access cycle");
        check_data(rdata, exp, "APB prdata");
    endtask

    task automatic lane_write(input int lane, input REG_IDX idx, input DATA data);
        write_en[lane]   = 1'b1;
        write_idx[lane]  = idx;
        write_data[lane] = data;
        @(posedge clock);
        #1;
        write_en[lane] = 1'b0;
    endtask

    // Reads one index on both ports of every lane
    task automatic check_reg(input REG_IDX idx, input DATA exp, input string what);
        for (int l = 0; l < NUM_FU; l++) begin
            read_idx_1[l] = idx;
            read_idx_2[l] = idx;
        end
        @(negedge clock);
        for (int l = 0; l < NUM_FU; l++) begin
            check_data(read_out_1[l], exp, $sformatf("%s, lane %0d port 1, index %0d",
                                                     what, l, idx));
            check_data(read_out_2[l], exp, $sformatf("%s, lane %0d port 2, index %0d",
                                                     what, l, idx));
        end
        @(posedge clock);
        #1;
    endtask

    ////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////

    // Called right after reset release
    task automatic test_clear();
        int busy;
        busy = 0;
        do begin
            @(negedge clock);
            if (init_busy) busy++;
            if (busy > WAIT_LIMIT) timeout_abort("fall of init_busy after reset");
        end while (init_busy);
        @(posedge clock);
        #1;
        check_flag(busy == PHYS_REG_SZ - 1, 1'b1, "init_busy length in cycles");
        for (int i = 0; i < PHYS_REG_SZ; i++) begin
            check_reg(REG_IDX'(i), ref_regs[i], "cleared register");
        end
    endtask

    task automatic test_lane_rw();
        REG_IDX idx [8];
        DATA    v;
        for (int n = 0; n < 8; n++) begin
            idx[n] = rand_idx();
            v = rand_data();
            lane_write(n % NUM_FU, idx[n], v);
            ref_regs[idx[n]] = v;
        end
        for (int n = 0; n < 8; n++) begin
            check_reg(idx[n], ref_regs[idx[n]], "lane readback");
        end
    endtask

    // Read and write of one index in the same cycle
    task automatic test_bypass();
        REG_IDX idx;
        DATA    v;
        idx = rand_idx();
        v = rand_data();
        write_en[0]   = 1'b1;
        write_idx[0]  = idx;
        write_data[0] = v;
        read_idx_1[1] = idx;
        read_idx_2[0] = idx;
        @(negedge clock);
        check_data(read_out_1[1], v, "bypass lane 1 port 1");
        check_data(read_out_2[0], v, "bypass lane 0 port 2");
        @(posedge clock);
        #1;
        write_en[0] = 1'b0;
        ref_regs[idx] = v;
        check_reg(idx, v, "after bypassed write");
    endtask

    task automatic test_zero_reg();
        lane_write(1, ZERO_REG, rand_data());
        apb_write(apb_addr(ZERO_REG), rand_data(), 1'b0);
        check_reg(ZERO_REG, '0, "zero register");
        apb_read(apb_addr(ZERO_REG), '0, 1'b0);
    endtask

    task automatic test_apb_rw();
        REG_IDX idx;
        DATA    v;
        for (int n = 0; n < 4; n++) begin
            idx = rand_idx();
            v = rand_data();
            apb_write(apb_addr(idx), v, 1'b0);
            ref_regs[idx] = v;
            apb_read(apb_addr(idx), v, 1'b0);
            check_reg(idx, v, "APB written register");
        end
    endtask

    // Bits 8 and 9 each put the address out of range
    task automatic test_out_of_range();
        REG_IDX                idx;
        DATA                   v;
        logic [APB_ADDR_W-1:0] addr;
        for (int b = 8; b < APB_ADDR_W; b++) begin
            idx = rand_idx();
            // Nonzero content so a leaked read or write shows up
            v = rand_data() | DATA'(1);
            lane_write(0, idx, v);
            ref_regs[idx] = v;
            addr = apb_addr(idx);
            addr[b] = 1'b1;
            apb_write(addr, ~v, 1'b1);
            apb_read(addr, '0, 1'b1);
            check_reg(idx, ref_regs[idx], "register behind out-of-range address");
        end
    endtask

    // Lane write held across the whole APB write to the same index
    task automatic test_priority();
        REG_IDX idx;
        DATA    apb_v;
        idx = rand_idx();
        apb_v = rand_data();
        write_en[1]   = 1'b1;
        write_idx[1]  = idx;
        write_data[1] = rand_data();
        apb_write(apb_addr(idx), apb_v, 1'b0);
        write_en[1] = 1'b0;
        ref_regs[idx] = apb_v;
        check_reg(idx, apb_v, "APB over lane write");
    endtask

    task automatic test_apb_in_clear();
        REG_IDX idx;
        DATA    rdata;
        logic   err;
        int     waits;
        int     busy_waits;
        idx = rand_idx();
        // Nonzero content that the second clearing must remove
        lane_write(0, idx, rand_data() | DATA'(1));
        reset_dut();
        apb_xfer(1'b0, apb_addr(idx), '0, rdata, err, waits, busy_waits);
        check_flag(busy_waits > 0, 1'b1, "access phase began during clearing");
        check_flag(waits - busy_waits == 2, 1'b1, "pready two cycles after clearing");
        check_flag(err, 1'b0, "pslverr after clearing");
        check_data(rdata, '0, "prdata after clearing");
        for (int i = 0; i < PHYS_REG_SZ; i++) begin
            check_reg(REG_IDX'(i), ref_regs[i], "register after second clearing");
        end
    endtask

    ////////////////////////////////////////
    // Sequence
    ////////////////////////////////////////

    initial begin
        int start;
        seed       = 58;
        reset      = 1'b1;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        read_idx_1 = '0;
        read_idx_2 = '0;
        write_en   = '0;
        write_idx  = '0;
        write_data = '0;

        reset_dut();
        start = errors;
        test_clear();
        report_test("clear", start);
        start = errors;
        test_lane_rw();
        report_test("lane_rw", start);
        start = errors;
        test_bypass();
        report_test("bypass", start);
        start = errors;
        test_zero_reg();
        report_test("zero_reg", start);
        start = errors;
        test_apb_rw();
        report_test("apb_rw", start);
        start = errors;
        test_out_of_range();
        report_test("out_of_range", start);
        start = errors;
        test_priority();
        report_test("priority", start);
        start = errors;
        test_apb_in_clear();
        report_test("apb_in_clear", start);

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== prf_top.sv ====
/*
 * Physical register file subsystem top
 * Joins the debug controller, the index counter and the register file
 */

module prf_top
    import sys_defs_pkg::*;
(
    input  logic                  clock,
    input  logic                  reset,
    // APB slave
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [APB_ADDR_W-1:0] paddr,
    input  DATA                   pwdata,
    output DATA                   prdata,
    output logic                  pready,
    output logic                  pslverr,
    output logic                  init_busy,
    // Lane ports
    input  REG_IDX [NUM_FU-1:0]   read_idx_1,
    input  REG_IDX [NUM_FU-1:0]   read_idx_2,
    output DATA    [NUM_FU-1:0]   read_out_1,
    output DATA    [NUM_FU-1:0]   read_out_2,
    input  logic   [NUM_FU-1:0]   write_en,
    input  REG_IDX [NUM_FU-1:0]   write_idx,
    input  DATA    [NUM_FU-1:0]   write_data
);

    // Controller to counter
    logic   count_en;
    REG_IDX index;
    logic   last;
    // Controller to register file
    REG_IDX dbg_read_idx;
    DATA    dbg_read_data;
    logic   dbg_write_en;
    REG_IDX dbg_write_idx;
    DATA    dbg_write_data;

    prf_debug_ctrl ctrl0 (
        .clock         (clock),
        .reset         (reset),
        .psel          (psel),
        .penable       (penable),
        .pwrite        (pwrite),
        .paddr         (paddr),
        .pwdata        (pwdata),
        .prdata        (prdata),
        .pready        (pready),
        .pslverr       (pslverr),
        .init_busy     (init_busy),
        .count_en      (count_en),
        .index         (index),
        .last          (last),
        .dbg_read_idx  (dbg_read_idx),
        .dbg_read_data (dbg_read_data),
        .dbg_write_en  (dbg_write_en),
        .dbg_write_idx (dbg_write_idx),
        .dbg_write_data(dbg_write_data)
    );

    prf_index_counter cnt0 (
        .clock   (clock),
        .reset   (reset),
        .count_en(count_en),
        .index   (index),
        .last    (last)
    );

    regfile rf0 (
        .clock         (clock),
        .read_idx_1    (read_idx_1),
        .read_idx_2    (read_idx_2),
        .write_idx     (write_idx),
        .write_en      (write_en),
        .write_data    (write_data),
        .read_out_1    (read_out_1),
        .read_out_2    (read_out_2),
        .dbg_read_idx  (dbg_read_idx),
        .dbg_read_data (dbg_read_data),
        .dbg_write_en  (dbg_write_en),
        .dbg_write_idx (dbg_write_idx),
        .dbg_write_data(dbg_write_data)
    );

endmodule

// ==== regfile.sv ====
/*
 * Physical register file
 * Two read ports and one write port per lane, plus a debug port pair,
 * register zero reads as zero and ignores writes
 */

module regfile
    import sys_defs_pkg::*;
(
    input  logic                clock,
    // Lane ports
    input  REG_IDX [NUM_FU-1:0] read_idx_1,
    input  REG_IDX [NUM_FU-1:0] read_idx_2,
    input  REG_IDX [NUM_FU-1:0] write_idx,
    input  logic   [NUM_FU-1:0] write_en,
    input  DATA    [NUM_FU-1:0] write_data,
    output DATA    [NUM_FU-1:0] read_out_1,
    output DATA    [NUM_FU-1:0] read_out_2,
    // Debug ports
    input  REG_IDX              dbg_read_idx,
    output DATA                 dbg_read_data,
    input  logic                dbg_write_en,
    input  REG_IDX              dbg_write_idx,
    input  DATA                 dbg_write_data
);

    // Raw memory data before the zero register is masked
    DATA [NUM_FU-1:0] rdata1;
    DATA [NUM_FU-1:0] rdata2;
    DATA              dbg_rdata;
    logic [NUM_FU-1:0] re1;
    logic [NUM_FU-1:0] re2;
    logic              dbg_re;
    logic [NUM_FU-1:0] lane_we;
    logic              dbg_we;

    // Port order: lanes first, debug last so it wins on writes
    mem_dp #(
        .WIDTH      ($bits(DATA)),
        .DEPTH      (PHYS_REG_SZ),
        .READ_PORTS (2*NUM_FU + 1),
        .WRITE_PORTS(NUM_FU + 1),
        .BYPASS_EN  (1'b1)
    ) prf_mem (
        .clock(clock),
        .reset(1'b0),
        .re   ({dbg_re, re2, re1}),
        .raddr({dbg_read_idx, read_idx_2, read_idx_1}),
        .rdata({dbg_rdata, rdata2, rdata1}),
        .we   ({dbg_we, lane_we}),
        .waddr({dbg_write_idx, write_idx}),
        .wdata({dbg_write_data, write_data})
    );

    // Lane reads and writes, zero register masked
    always_comb begin
        for (int i = 0; i < NUM_FU; i++) begin
            re1[i]        = (read_idx_1[i] != ZERO_REG);
            re2[i]        = (read_idx_2[i] != ZERO_REG);
            read_out_1[i] = re1[i] ? rdata1[i] : '0;
            read_out_2[i] = re2[i] ? rdata2[i] : '0;
            lane_we[i]    = write_en[i] & (write_idx[i] != ZERO_REG);
        end
    end

    // Debug port follows the same rule
    assign dbg_re        = (dbg_read_idx != ZERO_REG);
    assign dbg_read_data = dbg_re ? dbg_rdata : '0;
    assign dbg_we        = dbg_write_en & (dbg_write_idx != ZERO_REG);

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the register file testbench with Verilator
set -eo pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module prf_tb -f vlog.f -o prf_sim

./obj_dir/prf_sim | tee sim.log

if grep -q "sim failed" sim.log; then
    echo "run.sh: testbench reported failure"
    exit 1
fi
echo "run.sh: no failure reported"

// ==== sys_defs_pkg.sv ====
/*
 * Core definitions for the physical register file subsystem
 * Register geometry, value and index types, APB window layout
 */

package sys_defs_pkg;

    ////////////////////////////////////////
    // Register file geometry
    ////////////////////////////////////////

    // Physical registers, R10K style
    localparam int PHYS_REG_SZ = 64;
    // Execution lanes with their own read and write ports
    localparam int NUM_FU = 2;
    localparam int XLEN = 32;
    localparam int REG_IDX_W = $clog2(PHYS_REG_SZ);

    // One register value
    typedef logic [XLEN-1:0] DATA;
    // One physical register index
    typedef logic [REG_IDX_W-1:0] REG_IDX;

    // Hard-wired zero register
    localparam REG_IDX ZERO_REG = '0;
    // Highest index, end of the clearing walk
    localparam REG_IDX LAST_REG = REG_IDX'(PHYS_REG_SZ - 1);

    ////////////////////////////////////////
    // APB register window
    ////////////////////////////////////////

    localparam int APB_ADDR_W = 10;
    // Word aligned, so the index starts at bit 2
    localparam int APB_IDX_LSB = 2;
    localparam int APB_IDX_MSB = APB_IDX_LSB + REG_IDX_W - 1;
    // Any bit set from here up is out of range
    localparam int APB_HI_LSB = APB_IDX_MSB + 1;

endpackage

// ==== vlog.f ====
sys_defs_pkg.sv
mem_dp.sv
regfile.sv
prf_index_counter.sv
prf_debug_ctrl.sv
prf_top.sv
prf_properties.sv
prf_tb.sv
